// ==== vlog.f ====
+incdir+verilog
verilog/elem_pkg.sv
verilog/elem_cmd_decode.sv
verilog/elem_env_seq.sv
verilog/elem_ammod.sv
verilog/elem_mixacc.sv
verilog/elem_top.sv
tests/elem_mem_model.sv
tests/elem_tb.sv

// ==== Bender.yml ====
package:
  name: elem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/elem_pkg.sv
      - verilog/elem_cmd_decode.sv
      - verilog/elem_env_seq.sv
      - verilog/elem_ammod.sv
      - verilog/elem_mixacc.sv
      - verilog/elem_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/elem_mem_model.sv
      - tests/elem_tb.sv

// ==== tests/elem_tb.sv ====
// directed testbench for the waveform element with a software model of pulse and demodulation
`include "elem_defines.svh"

module elem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import elem_pkg::*;

	localparam int trig_lead  = 12;
	localparam int len_basic  = 40;
	localparam int len_wrong  = 30;
	localparam int len_first  = 25;
	localparam int len_second = 33;
	localparam int len_retrig = 20;
	localparam int len_new    = 15;
	localparam int retrig_gap = 10;
	// each command waits for its trigger, runs its length and drains for about 30 cycles
	localparam int max_cycles = 40 + 6 * (trig_lead + 30) + len_basic + len_wrong
		+ len_first + len_second + len_retrig + len_new + 200;

	logic                     elem;
	logic                     rst_n;
	elem_cmd_t                cmd;
	logic [`ELEM_ENV_AW-1:0]  env_addr;
	elem_iq_t                 env_data;
	logic [`ELEM_FREQ_AW-1:0] freq_addr;
	elem_iq_t                 freq_data;
	elem_iq_t                 adc;
	logic [4:0]               shift;
	elem_sample_t             out;
	elem_acc_t                acc;
	int                       cyc = 0;

	// captured at the falling edge, model queue built from the ROM contents
	elem_iq_t  out_seen[$];
	elem_iq_t  adc_seen[$];
	elem_acc_t acc_seen[$];
	elem_iq_t  exp_out[$];

	elem_top #(
		.element_mode(mode_readout)
	) dut0 (
		.elem      (elem),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.env_addr  (env_addr),
		.env_data  (env_data),
		.freq_addr (freq_addr),
		.freq_data (freq_data),
		.adc       (adc),
		.shift     (shift),
		.out       (out),
		.acc       (acc)
	);

	elem_mem_model mem0 (
		.elem      (elem),
		.env_addr  (env_addr),
		.env_data  (env_data),
		.freq_addr (freq_addr),
		.freq_data (freq_data)
	);

	initial begin
		elem = 1'b0;
		forever #5 elem = ~elem;
	end

	always @(posedge elem) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("timeout: the run took more than %0d cycles", max_cycles);
			$display("Test failed");
			$fatal(1);
		end
	end

	always @(posedge elem) begin
		#1;
		adc = $urandom;
	end

	always @(negedge elem) begin
		if (rst_n) begin
			if (out.valid) begin
				out_seen.push_back(out.iq);
				adc_seen.push_back(adc);
			end
			if (acc.stb) begin
				acc_seen.push_back(acc);
			end
		end
	end

	task automatic expect_equal(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// envelope times carrier, then amplitude, each part >>> 15 and cut to 16 bits
	function automatic elem_iq_t modulate(elem_iq_t env, elem_iq_t car, logic signed [15:0] amp);
		logic signed [63:0] re;
		logic signed [63:0] im;
		logic signed [15:0] px;
		logic signed [15:0] py;
		elem_iq_t           r;
		re = (env.x * car.x - env.y * car.y) >>> 15;
		im = (env.x * car.y + env.y * car.x) >>> 15;
		px = re[15:0];
		py = im[15:0];
		re = (px * amp) >>> 15;
		im = (py * amp) >>> 15;
		r.x = re[15:0];
		r.y = im[15:0];
		return r;
	endfunction

	// sum of the 32-bit complex products adc * out over one window
	function automatic elem_acc_t expected_result(int first, int count, logic [4:0] sh);
		logic signed [`ELEM_ACC_GUARD+31:0] sx;
		logic signed [`ELEM_ACC_GUARD+31:0] sy;
		logic signed [63:0]                 full;
		logic signed [31:0]                 part;
		elem_iq_t                           a;
		elem_iq_t                           o;
		elem_acc_t                          r;
		sx = '0;
		sy = '0;
		for (int i = first; i < first + count; i++) begin
			a = adc_seen[i];
			o = exp_out[i];
			full = a.x * o.x - a.y * o.y;
			part = full[31:0];
			sx = sx + part;
			full = a.x * o.y + a.y * o.x;
			part = full[31:0];
			sy = sy + part;
		end
		r.stb = 1'b1;
		full = sx >>> sh;
		r.x = full[31:0];
		full = sy >>> sh;
		r.y = full[31:0];
		return r;
	endfunction

	task automatic add_expected(input logic [`ELEM_ENV_AW-1:0] st, input int count,
			input logic signed [15:0] amp, input logic [`ELEM_FREQ_AW-1:0] fb);
		logic [`ELEM_ENV_AW-1:0]  ea;
		logic [`ELEM_FREQ_AW-1:0] fa;
		for (int k = 0; k < count; k++) begin
			ea = st + k;
			// carrier address wraps with the 512-entry table
			fa = fb + k;
			exp_out.push_back(modulate(mem0.env_rom[ea], mem0.freq_rom[fa], amp));
		end
	endtask

	task automatic send_cmd(input elem_mode_e mode, input int trig,
			input logic [`ELEM_ENV_AW-1:0] st, input logic [`ELEM_ENV_AW-1:0] len,
			input logic signed [15:0] amp, input logic [`ELEM_FREQ_AW-1:0] fb);
		@(posedge elem);
		#1;
		cmd.mode       = mode;
		cmd.trig_time  = trig;
		cmd.env_start  = st;
		cmd.env_length = len;
		cmd.amp        = amp;
		cmd.freq_base  = fb;
	endtask

	task automatic clear_capture();
		out_seen.delete();
		adc_seen.delete();
		acc_seen.delete();
		exp_out.delete();
	endtask

	// a few extra cycles catch a stray strobe or sample
	task automatic wait_strobes(input int n);
		while (acc_seen.size() < n) begin
			@(posedge elem);
		end
		repeat (8) @(posedge elem);
	endtask

	task automatic compare_samples();
		expect_equal("out.valid count", exp_out.size(), out_seen.size());
		for (int i = 0; i < exp_out.size(); i++) begin
			expect_equal($sformatf("out.iq[%0d]", i), exp_out[i], out_seen[i]);
		end
	endtask

	task automatic compare_result(input int idx, input int first, input int count,
			input logic [4:0] sh);
		elem_acc_t exp;
		exp = expected_result(first, count, sh);
		expect_equal($sformatf("acc.x[%0d]", idx), exp.x, acc_seen[idx].x);
		expect_equal($sformatf("acc.y[%0d]", idx), exp.y, acc_seen[idx].y);
	endtask

	task automatic idle_stays_quiet();
		repeat (20) @(posedge elem);
		expect_equal("out.valid count", 0, out_seen.size());
		expect_equal("acc.stb count", 0, acc_seen.size());
	endtask

	task automatic single_pulse();
		int trig;
		clear_capture();
		trig = cyc + trig_lead;
		send_cmd(mode_readout, trig, 12'd100, len_basic, 16'sd23000, 9'd490);
		shift = 5'd12;
		add_expected(12'd100, len_basic + 1, 16'sd23000, 9'd490);
		wait_strobes(1);
		compare_samples();
		expect_equal("acc.stb count", 1, acc_seen.size());
		compare_result(0, 0, len_basic + 1, 5'd12);
	endtask

	task automatic wrong_mode_ignored();
		int trig;
		clear_capture();
		trig = cyc + trig_lead;
		send_cmd(mode_flux, trig, 12'd50, len_wrong, 16'sd20000, 9'd0);
		repeat (trig_lead + len_wrong + 20) @(posedge elem);
		expect_equal("out.valid count", 0, out_seen.size());
		expect_equal("acc.stb count", 0, acc_seen.size());
	endtask

	task automatic two_separate_pulses();
		int trig;
		clear_capture();
		trig = cyc + trig_lead;
		send_cmd(mode_readout, trig, 12'd600, len_first, -16'sd12000, 9'd7);
		shift = 5'd9;
		add_expected(12'd600, len_first + 1, -16'sd12000, 9'd7);
		wait_strobes(1);
		trig = cyc + trig_lead;
		send_cmd(mode_readout, trig, 12'd1500, len_second, 16'sd31000, 9'd260);
		shift = 5'd14;
		add_expected(12'd1500, len_second + 1, 16'sd31000, 9'd260);
		wait_strobes(2);
		compare_samples();
		expect_equal("acc.stb count", 2, acc_seen.size());
		compare_result(0, 0, len_first + 1, 5'd9);
		compare_result(1, len_first + 1, len_second + 1, 5'd14);
	endtask

	// second command lands mid-pulse, carrier offset kept in step with the first
	task automatic retrigger_restarts();
		int trig_a;
		clear_capture();
		trig_a = cyc + trig_lead;
		send_cmd(mode_readout, trig_a, 12'd200, len_retrig, 16'sd18000, 9'd300);
		shift = 5'd11;
		while (cyc < trig_a + 5) begin
			@(posedge elem);
		end
		send_cmd(mode_readout, trig_a + retrig_gap, 12'd205, len_new, 16'sd18000, 9'd305);
		add_expected(12'd200, retrig_gap, 16'sd18000, 9'd300);
		add_expected(12'd205, len_new + 1, 16'sd18000, 9'd305);
		wait_strobes(1);
		compare_samples();
		expect_equal("acc.stb count", 1, acc_seen.size());
		compare_result(0, 0, retrig_gap + len_new + 1, 5'd11);
	endtask

	initial begin
		rst_n = 1'b0;
		cmd   = '0;
		adc   = '0;
		shift = '0;
		void'($urandom(32'hb1677c2b));
		mem0.fill_tables();
		repeat (3) @(posedge elem);
		#1;
		rst_n = 1'b1;
		idle_stays_quiet();
		single_pulse();
		wrong_mode_ignored();
		two_separate_pulses();
		retrigger_restarts();
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== tests/elem_mem_model.sv ====
// envelope and carrier ROMs for the testbench, read through a fixed latency pipeline
`include "elem_defines.svh"

module elem_mem_model (
	input  logic                     elem,
	input  logic [`ELEM_ENV_AW-1:0]  env_addr,
	output elem_pkg::elem_iq_t       env_data,
	input  logic [`ELEM_FREQ_AW-1:0] freq_addr,
	output elem_pkg::elem_iq_t       freq_data
);
	timeunit 1ns;
	timeprecision 100ps;

	import elem_pkg::*;

	localparam int lat = `ELEM_MEM_LATENCY;

	elem_iq_t env_rom   [2**`ELEM_ENV_AW];
	elem_iq_t freq_rom  [2**`ELEM_FREQ_AW];
	elem_iq_t env_pipe  [lat];
	elem_iq_t freq_pipe [lat];

	// called once the random generator has its seed
	task automatic fill_tables();
		for (int a = 0; a < 2**`ELEM_ENV_AW; a++) begin
			env_rom[a] = $urandom;
		end
		for (int a = 0; a < 2**`ELEM_FREQ_AW; a++) begin
			freq_rom[a] = $urandom;
		end
	endtask

	always_ff @(posedge elem) begin
		env_pipe[0]  <= env_rom[env_addr];
		freq_pipe[0] <= freq_rom[freq_addr];
		for (int i = 1; i < lat; i++) begin
			env_pipe[i]  <= env_pipe[i-1];
			freq_pipe[i] <= freq_pipe[i-1];
		end
	end

	assign env_data  = env_pipe[lat-1];
	assign freq_data = freq_pipe[lat-1];

endmodule

// ==== verilog/elem_top.sv ====
// waveform element: command decode, table sequencer, modulator and demodulator
`include "elem_defines.svh"

module elem_top #(
	parameter elem_pkg::elem_mode_e element_mode = elem_pkg::mode_drive
) (
	input  logic                     elem,
	input  logic                     rst_n,
	input  elem_pkg::elem_cmd_t      cmd,
	output logic [`ELEM_ENV_AW-1:0]  env_addr,
	input  elem_pkg::elem_iq_t       env_data,
	output logic [`ELEM_FREQ_AW-1:0] freq_addr,
	input  elem_pkg::elem_iq_t       freq_data,
	input  elem_pkg::elem_iq_t       adc,
	input  logic [4:0]               shift,
	output elem_pkg::elem_sample_t   out,
	output elem_pkg::elem_acc_t      acc
);

	import elem_pkg::*;

	logic      start;
	elem_cmd_t active_cmd;
	logic      gate;

	elem_cmd_decode #(
		.element_mode(element_mode)
	) u_decode (
		.elem       (elem),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.start      (start),
		.active_cmd (active_cmd)
	);

	elem_env_seq u_env_seq (
		.elem       (elem),
		.rst_n      (rst_n),
		.start      (start),
		.active_cmd (active_cmd),
		.env_addr   (env_addr),
		.freq_addr  (freq_addr),
		.gate       (gate)
	);

	// amplitude comes straight from the latched command
	elem_ammod u_ammod (
		.elem      (elem),
		.rst_n     (rst_n),
		.gate      (gate),
		.env_data  (env_data),
		.freq_data (freq_data),
		.amp       (active_cmd.amp),
		.out       (out)
	);

	elem_mixacc u_mixacc (
		.elem  (elem),
		.rst_n (rst_n),
		.out   (out),
		.adc   (adc),
		.shift (shift),
		.acc   (acc)
	);

endmodule

// ==== verilog/elem_mixacc.sv ====
// demodulator: adc times outgoing sample, accumulated per valid window
`include "elem_defines.svh"

module elem_mixacc (
	input  logic                   elem,
	input  logic                   rst_n,
	input  elem_pkg::elem_sample_t out,
	input  elem_pkg::elem_iq_t     adc,
	input  logic [4:0]             shift,
	output elem_pkg::elem_acc_t    acc
);

	import elem_pkg::*;

	localparam int ACC_W = 32 + `ELEM_ACC_GUARD;

	elem_iq_t                adc_q;
	elem_iq_t                dlo_q;
	logic                    valid_q;
	logic                    valid_qq;
	logic signed [31:0]      m_xx;
	logic signed [31:0]      m_yy;
	logic signed [31:0]      m_xy;
	logic signed [31:0]      m_yx;
	logic signed [31:0]      mix_x;
	logic signed [31:0]      mix_y;
	logic signed [ACC_W-1:0] sum_x;
	logic signed [ACC_W-1:0] sum_y;
	logic signed [ACC_W-1:0] next_x;
	logic signed [ACC_W-1:0] next_y;
	logic signed [ACC_W-1:0] shr_x;
	logic signed [ACC_W-1:0] shr_y;
	logic                    window_end;
	logic                    stb_q;
	logic signed [31:0]      res_x;
	logic signed [31:0]      res_y;

	assign m_xx = adc_q.x * dlo_q.x;
	assign m_yy = adc_q.y * dlo_q.y;
	assign m_xy = adc_q.x * dlo_q.y;
	assign m_yx = adc_q.y * dlo_q.x;

	// full 32-bit parts of adc * out
	assign mix_x = m_xx - m_yy;
	assign mix_y = m_xy + m_yx;

	// first sample of a window loads instead of adding
	assign next_x = valid_qq ? (sum_x + mix_x) : mix_x;
	assign next_y = valid_qq ? (sum_y + mix_y) : mix_y;

	assign shr_x = next_x >>> shift;
	assign shr_y = next_y >>> shift;

	// last product is in flight while the input valid has already dropped
	assign window_end = valid_q && !out.valid;

	always_ff @(posedge elem) begin
		adc_q <= adc;
		dlo_q <= out.iq;
		if (valid_q) begin
			sum_x <= next_x;
			sum_y <= next_y;
		end
		if (window_end) begin
			res_x <= shr_x[31:0];
			res_y <= shr_y[31:0];
		end
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			valid_q  <= 1'b0;
			valid_qq <= 1'b0;
			stb_q    <= 1'b0;
		end else begin
			valid_q  <= out.valid;
			valid_qq <= valid_q;
			stb_q    <= window_end;
		end
	end

	assign acc.stb = stb_q;
	assign acc.x   = res_x;
	assign acc.y   = res_y;

	stb_after_fall_a: assert property (
		@(posedge elem) disable iff (!rst_n)
		acc.stb |-> $past(out.valid, 2) && !$past(out.valid)
	) else $error("acc.stb not two cycles after the end of the window");

endmodule

// ==== verilog/elem_ammod.sv ====
// two-stage modulator: complex envelope times carrier, then amplitude scaling
module elem_ammod (
	input  logic                  elem,
	input  logic                  rst_n,
	input  logic                  gate,
	input  elem_pkg::elem_iq_t    env_data,
	input  elem_pkg::elem_iq_t    freq_data,
	input  logic signed [15:0]    amp,
	output elem_pkg::elem_sample_t out
);

	import elem_pkg::*;

	// stage one partial products
	logic signed [31:0] p_xx;
	logic signed [31:0] p_yy;
	logic signed [31:0] p_xy;
	logic signed [31:0] p_yx;
	logic signed [32:0] sum_x;
	logic signed [32:0] sum_y;
	elem_iq_t           prod_q;
	logic               valid1_q;

	// stage two amplitude products
	logic signed [31:0] amp_x;
	logic signed [31:0] amp_y;
	elem_iq_t           out_iq_q;
	logic               valid2_q;

	assign p_xx = env_data.x * freq_data.x;
	assign p_yy = env_data.y * freq_data.y;
	assign p_xy = env_data.x * freq_data.y;
	assign p_yx = env_data.y * freq_data.x;

	// complex product, one guard bit before the Q1.15 rescale
	assign sum_x = p_xx - p_yy;
	assign sum_y = p_xy + p_yx;

	assign amp_x = prod_q.x * amp;
	assign amp_y = prod_q.y * amp;

	// >>> 15 and truncate to 16 bits is the [30:15] slice
	always_ff @(posedge elem) begin
		prod_q.x   <= sum_x[30:15];
		prod_q.y   <= sum_y[30:15];
		out_iq_q.x <= amp_x[30:15];
		out_iq_q.y <= amp_y[30:15];
	end

	// valid travels with the data through both stages
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			valid1_q <= 1'b0;
			valid2_q <= 1'b0;
		end else begin
			valid1_q <= gate;
			valid2_q <= valid1_q;
		end
	end

	assign out.valid = valid2_q;
	assign out.iq    = out_iq_q;

	valid_known_a: assert property (
		@(posedge elem) disable iff (!rst_n)
		!$isunknown(out.valid) && (!out.valid || !$isunknown(out.iq))
	) else $error("out.valid or a valid sample unknown after reset");

endmodule

// ==== verilog/elem_env_seq.sv ====
// envelope and carrier address sequencer with busy gate aligned to table data
`include "elem_defines.svh"

module elem_env_seq (
	input  logic                     elem,
	input  logic                     rst_n,
	input  logic                     start,
	input  elem_pkg::elem_cmd_t      active_cmd,
	output logic [`ELEM_ENV_AW-1:0]  env_addr,
	output logic [`ELEM_FREQ_AW-1:0] freq_addr,
	output logic                     gate
);

	import elem_pkg::*;

	// one cycle for the address register plus the table read
	localparam int GATE_DLY = 1 + `ELEM_MEM_LATENCY;

	elem_seq_state_e          state;
	elem_seq_state_e          state_nxt;
	logic [`ELEM_ENV_AW-1:0]  cnt;
	logic [`ELEM_ENV_AW-1:0]  cnt_end;
	logic [`ELEM_ENV_AW-1:0]  offset;
	logic                     at_end;
	logic                     busy;
	logic [GATE_DLY-1:0]      gate_sr;

	assign cnt_end = active_cmd.env_start + active_cmd.env_length;
	assign at_end  = (cnt == cnt_end);
	assign busy    = (state == seq_run);
	assign offset  = cnt - active_cmd.env_start;

	always_comb begin
		state_nxt = state;
		case (state)
			seq_idle: begin
				if (start) begin
					state_nxt = seq_run;
				end
			end
			seq_run: begin
				// a start here restarts, the run continues
				if (!start && at_end) begin
					state_nxt = seq_idle;
				end
			end
			default: state_nxt = seq_idle;
		endcase
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			state   <= seq_idle;
			cnt     <= '0;
			gate_sr <= '0;
		end else begin
			state   <= state_nxt;
			gate_sr <= {gate_sr[GATE_DLY-2:0], busy};
			if (start) begin
				cnt <= active_cmd.env_start;
			end else if (busy && !at_end) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// carrier offset follows the envelope offset, wraps with the table
	always_ff @(posedge elem) begin
		env_addr  <= cnt;
		freq_addr <= active_cmd.freq_base + offset[`ELEM_FREQ_AW-1:0];
	end

	assign gate = gate_sr[GATE_DLY-1];

	// restart cycle still carries the old count against the new window
	addr_range_a: assert property (
		@(posedge elem) disable iff (!rst_n)
		busy && !start |=> (env_addr >= $past(active_cmd.env_start))
			&& (env_addr <= $past(cnt_end))
	) else $error("env_addr outside the command window");

endmodule

// ==== verilog/elem_cmd_decode.sv ====
// command decode: free-running time counter, trigger compare and command latch
`include "elem_defines.svh"

module elem_cmd_decode #(
	parameter elem_pkg::elem_mode_e element_mode = elem_pkg::mode_drive
) (
	input  logic                elem,
	input  logic                rst_n,
	input  elem_pkg::elem_cmd_t cmd,
	output logic                start,
	output elem_pkg::elem_cmd_t active_cmd
);

	logic [`ELEM_TCNT_W-1:0] tcnt;
	logic                    hit;

	// element time base, trigger times are absolute counts of it
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			tcnt <= '0;
		end else begin
			tcnt <= tcnt + 1'b1;
		end
	end

	// fire only on our own channel mode, other elements share the bus
	assign hit = (tcnt == cmd.trig_time) && (cmd.mode == element_mode);

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
		end else begin
			start <= hit;
		end
	end

	// command is captured on the same edge that raises start
	// so the sequencer sees the new fields together with the pulse
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			active_cmd <= '0;
		end else if (hit) begin
			active_cmd <= cmd;
		end
	end

	// counter moves every cycle, so a held command cannot match twice in a row
	start_single_a: assert property (
		@(posedge elem) disable iff (!rst_n)
		start |=> !start
	) else $error("start high for more than one cycle");

endmodule

// ==== verilog/elem_pkg.sv ====
// waveform element types: channel modes, sequencer states, command and sample structs
`include "elem_defines.svh"

package elem_pkg;

	// channel mode, also the opcode carried by each command
	typedef enum logic [1:0] {
		mode_drive   = 2'd0,
		mode_readout = 2'd1,
		mode_flux    = 2'd2,
		mode_aux     = 2'd3
	} elem_mode_e;

	typedef enum logic {
		seq_idle = 1'b0,
		seq_run  = 1'b1
	} elem_seq_state_e;

	// one pulse command, amp is Q1.15
	typedef struct packed {
		elem_mode_e                mode;
		logic [`ELEM_TCNT_W-1:0]   trig_time;
		logic [`ELEM_ENV_AW-1:0]   env_start;
		logic [`ELEM_ENV_AW-1:0]   env_length;
		logic signed [15:0]        amp;
		logic [`ELEM_FREQ_AW-1:0]  freq_base;
	} elem_cmd_t;

	// complex Q1.15 pair
	typedef struct packed {
		logic signed [15:0] x;
		logic signed [15:0] y;
	} elem_iq_t;

	typedef struct packed {
		logic     valid;
		elem_iq_t iq;
	} elem_sample_t;

	// demodulated result with its strobe
	typedef struct packed {
		logic               stb;
		logic signed [31:0] x;
		logic signed [31:0] y;
	} elem_acc_t;

endpackage

// ==== verilog/elem_defines.svh ====
// waveform element widths, table latency and accumulator guard bits
`ifndef ELEM_DEFINES_SVH
`define ELEM_DEFINES_SVH

// time counter and trigger time
`define ELEM_TCNT_W 27

// envelope address, start and length
`define ELEM_ENV_AW 12

// carrier table address, table wraps at 512 entries
`define ELEM_FREQ_AW 9

// read latency of the envelope and carrier tables in cycles
`define ELEM_MEM_LATENCY 1

// extra accumulator bits above the 32-bit product
`define ELEM_ACC_GUARD 16

`endif
